// File: common/laser_line_pkg.sv
package laser_line_pkg;

    // Transmit side of a lane pair
    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_e;

    // Receive side, idle until a start edge
    typedef enum logic {
        RX_IDLE,
        RX_RECEIVE
    } rx_state_e;

    // Position within a frame, 0..FRAME_BITS
    typedef logic [3:0] bit_count_t;

endpackage

// File: common/laser_link_defines.svh
`ifndef LASER_LINK_DEFINES_SVH
`define LASER_LINK_DEFINES_SVH

// Line timing, in clock cycles per line bit
`define BIT_CLOCKS      8

// Start bit, eight data bits LSB first, stop bit
`define FRAME_BITS      10

// Vote window and sample point, counted 1..BIT_CLOCKS within a bit
`define VOTE_FIRST      3
`define VOTE_LAST       5
`define SAMPLE_POINT    8

// Handshake pattern seen on the two lanes
`define HS_LANE1        8'h55
`define HS_LANE2        8'hAA

// Same byte on both lanes ends the link
`define DONE_CODE       8'hAA

// Consecutive handshake frames before the link counts as up
`define HS_REPEAT       4

`endif

// File: common/link_pkg.sv
package link_pkg;

    // One byte per lane, lane 1 in the low byte
    typedef struct packed {
        logic [7:0] lane2;
        logic [7:0] lane1;
    } byte_pair_t;

    // Link monitor states
    typedef enum logic {
        LINK_DOWN,
        LINK_UP
    } link_state_e;

endpackage

// File: common/rx_frame_if.sv
`timescale 1ns/1ps

interface rx_frame_if
    import link_pkg::*;
();
    logic       valid;
    byte_pair_t pair;
    logic       frame_error;
    logic       link_up;

    modport source  (output valid, pair, frame_error);

    modport monitor (input valid, pair, frame_error, output link_up);

    modport sink    (input valid, pair, frame_error, link_up);

endinterface

// File: hdl/laser_link_top.sv
`timescale 1ns/1ps

module laser_link_top
    import link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       tx_valid,
    input  logic [7:0] tx_data1,
    input  logic [7:0] tx_data2,
    output logic       tx_ready,
    output logic       laser1_out,
    output logic       laser2_out,
    input  logic       laser1_in,
    input  logic       laser2_in,
    output logic       rx_valid,
    output logic       rx_frame_error,
    output logic       link_up,
    output logic [7:0] rx_data1,
    output logic [7:0] rx_data2
);

    byte_pair_t tx_pair;

    rx_frame_if frame_bus ();

    assign tx_pair.lane1 = tx_data1;
    assign tx_pair.lane2 = tx_data2;

    laser_serializer u_serializer (
        .clock      (clock),
        .reset      (reset),
        .tx_valid   (tx_valid),
        .tx_pair    (tx_pair),
        .tx_ready   (tx_ready),
        .laser1_out (laser1_out),
        .laser2_out (laser2_out)
    );

    laser_deserializer u_deserializer (
        .clock     (clock),
        .reset     (reset),
        .laser1_in (laser1_in),
        .laser2_in (laser2_in),
        .frame     (frame_bus.source)
    );

    link_monitor u_link_monitor (
        .clock (clock),
        .reset (reset),
        .frame (frame_bus.monitor)
    );

    // Receive results out to plain ports
    assign rx_valid       = frame_bus.valid;
    assign rx_frame_error = frame_bus.frame_error;
    assign link_up        = frame_bus.link_up;
    assign rx_data1       = frame_bus.pair.lane1;
    assign rx_data2       = frame_bus.pair.lane2;

endmodule

// File: hdl/link_monitor.sv
`timescale 1ns/1ps

`include "laser_link_defines.svh"

module link_monitor
    import link_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    rx_frame_if.monitor frame
);

    link_state_e state;
    logic [2:0]  hs_cnt;
    logic        hs_match;
    logic        done_match;

    assign hs_match   = (frame.pair.lane1 == `HS_LANE1) && (frame.pair.lane2 == `HS_LANE2);
    assign done_match = (frame.pair.lane1 == `DONE_CODE) && (frame.pair.lane2 == `DONE_CODE);

    assign frame.link_up = (state == LINK_UP);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state  <= LINK_DOWN;
            hs_cnt <= '0;
        end else begin
            case (state)
                LINK_DOWN: begin
                    if (frame.valid && hs_match) begin
                        hs_cnt <= hs_cnt + 3'd1;
                        if (hs_cnt == 3'(`HS_REPEAT - 1))
                            state <= LINK_UP;
                    end else if (frame.valid || frame.frame_error) begin
                        // Streak broken
                        hs_cnt <= '0;
                    end
                end
                LINK_UP: begin
                    if (frame.valid && done_match) begin
                        state  <= LINK_DOWN;
                        hs_cnt <= '0;
                    end
                end
                default: state <= LINK_DOWN;
            endcase
        end
    end

endmodule

// File: laser_rx/lane_sampler.sv
`timescale 1ns/1ps

`include "laser_link_defines.svh"

module lane_sampler (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   laser_in,
    input  logic                   vote_en,
    input  logic                   sample_strobe,
    input  logic                   frame_clear,
    output logic                   lane_sync,
    output logic [`FRAME_BITS-1:0] frame_bits
);

    logic       sync_meta;
    logic [1:0] vote_cnt;
    logic       majority;

    // Two of three samples high
    assign majority = (vote_cnt >= 2'd2);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            sync_meta <= 1'b0;
            lane_sync <= 1'b0;
            vote_cnt  <= '0;
        end else begin
            sync_meta <= laser_in;
            lane_sync <= sync_meta;
            if (sample_strobe)
                vote_cnt <= '0;
            else if (vote_en && lane_sync)
                vote_cnt <= vote_cnt + 2'd1;
        end
    end

    // New bits enter at the top, so the start bit ends up in bit 0
    always_ff @(posedge clock) begin
        if (frame_clear)
            frame_bits <= '0;
        else if (sample_strobe)
            frame_bits <= {majority, frame_bits[`FRAME_BITS-1:1]};
    end

endmodule

// File: laser_rx/laser_deserializer.sv
`timescale 1ns/1ps

`include "laser_link_defines.svh"

module laser_deserializer
    import laser_line_pkg::*;
    import link_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        laser1_in,
    input  logic        laser2_in,
    rx_frame_if.source  frame
);

    rx_state_e               state;
    logic [3:0]              period_cnt;
    bit_count_t              bit_cnt;
    logic                    check_pending;
    logic                    lane1_prev;
    logic                    lane2_prev;
    logic                    lane1_sync;
    logic                    lane2_sync;
    logic [`FRAME_BITS-1:0]  bits1;
    logic [`FRAME_BITS-1:0]  bits2;
    logic                    start_frame;
    logic                    vote_en;
    logic                    sample_strobe;
    logic                    frame_ok;
    byte_pair_t              rx_pair;

    lane_sampler u_lane1 (
        .clock         (clock),
        .reset         (reset),
        .laser_in      (laser1_in),
        .vote_en       (vote_en),
        .sample_strobe (sample_strobe),
        .frame_clear   (start_frame),
        .lane_sync     (lane1_sync),
        .frame_bits    (bits1)
    );

    lane_sampler u_lane2 (
        .clock         (clock),
        .reset         (reset),
        .laser_in      (laser2_in),
        .vote_en       (vote_en),
        .sample_strobe (sample_strobe),
        .frame_clear   (start_frame),
        .lane_sync     (lane2_sync),
        .frame_bits    (bits2)
    );

    // Rising edge on either lane opens a frame
    assign start_frame = (state == RX_IDLE) &&
                         ((lane1_sync && !lane1_prev) || (lane2_sync && !lane2_prev));

    assign vote_en = (state == RX_RECEIVE) &&
                     (period_cnt >= 4'(`VOTE_FIRST)) && (period_cnt <= 4'(`VOTE_LAST));
    assign sample_strobe = (state == RX_RECEIVE) && (period_cnt == 4'(`SAMPLE_POINT));

    // Start high and stop low on both lanes
    assign frame_ok = bits1[0] && !bits1[`FRAME_BITS-1] && bits2[0] && !bits2[`FRAME_BITS-1];

    assign rx_pair.lane1 = bits1[8:1];
    assign rx_pair.lane2 = bits2[8:1];

    assign frame.pair        = rx_pair;
    assign frame.valid       = check_pending && frame_ok;
    assign frame.frame_error = check_pending && !frame_ok;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state         <= RX_IDLE;
            period_cnt    <= 4'd1;
            bit_cnt       <= '0;
            check_pending <= 1'b0;
            lane1_prev    <= 1'b0;
            lane2_prev    <= 1'b0;
        end else begin
            lane1_prev    <= lane1_sync;
            lane2_prev    <= lane2_sync;
            check_pending <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    if (start_frame) begin
                        state      <= RX_RECEIVE;
                        // Edge cycle already counts as position 1
                        period_cnt <= 4'd2;
                    end
                end
                RX_RECEIVE: begin
                    period_cnt <= sample_strobe ? 4'd1 : period_cnt + 4'd1;
                    if (sample_strobe) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == bit_count_t'(`FRAME_BITS - 1)) begin
                            state         <= RX_IDLE;
                            check_pending <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: laser_tx/laser_serializer.sv
`timescale 1ns/1ps

`include "laser_link_defines.svh"

module laser_serializer
    import laser_line_pkg::*;
    import link_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       tx_valid,
    input  byte_pair_t tx_pair,
    output logic       tx_ready,
    output logic       laser1_out,
    output logic       laser2_out
);

    tx_state_e                state;
    logic [3:0]               period_cnt;
    bit_count_t               bit_cnt;
    logic [`FRAME_BITS-1:0]   frame1;
    logic [`FRAME_BITS-1:0]   frame2;
    logic                     accept;
    logic                     bit_end;

    assign tx_ready = (state == TX_IDLE);
    assign accept   = tx_valid && tx_ready;
    assign bit_end  = (state == TX_SEND) && (period_cnt == 4'(`BIT_CLOCKS - 1));

    // Current frame bit sits in bit 0, lanes low when idle
    assign laser1_out = (state == TX_SEND) && frame1[0];
    assign laser2_out = (state == TX_SEND) && frame2[0];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state      <= TX_IDLE;
            period_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    period_cnt <= '0;
                    bit_cnt    <= '0;
                    if (accept)
                        state <= TX_SEND;
                end
                TX_SEND: begin
                    period_cnt <= bit_end ? 4'd0 : period_cnt + 4'd1;
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        // Stop bit done, ready again next cycle
                        if (bit_cnt == bit_count_t'(`FRAME_BITS - 1))
                            state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Stop, data, start; shifted out LSB first
    always_ff @(posedge clock) begin
        if (accept) begin
            frame1 <= {1'b0, tx_pair.lane1, 1'b1};
            frame2 <= {1'b0, tx_pair.lane2, 1'b1};
        end else if (bit_end) begin
            frame1 <= {1'b0, frame1[`FRAME_BITS-1:1]};
            frame2 <= {1'b0, frame2[`FRAME_BITS-1:1]};
        end
    end

endmodule

// File: sim/laser_link_assert.sv
`timescale 1ns/1ps

`include "laser_link_defines.svh"

module laser_link_assert
    import laser_line_pkg::*;
(
    input logic      clock,
    input logic      reset,
    input logic      tx_valid,
    input logic      tx_ready,
    input tx_state_e tx_state,
    input logic      lane1,
    input logic      lane2,
    input logic      rx_valid,
    input logic      rx_error
);

    // Clocks left in the frame after an accepted pair
    int busy_left;
    int assert_fails = 0;

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            busy_left <= 0;
        else if (tx_valid && tx_ready)
            busy_left <= `FRAME_BITS * `BIT_CLOCKS;
        else if (busy_left != 0)
            busy_left <= busy_left - 1;
    end

    tx_busy_a: assert property (@(posedge clock) disable iff (reset)
        busy_left != 0 |-> !tx_ready)
        else begin
            $error("tx_ready high during a frame");
            assert_fails++;
        end

    rx_pulse_a: assert property (@(posedge clock) disable iff (reset)
        rx_valid |=> !rx_valid)
        else begin
            $error("rx valid longer than one cycle");
            assert_fails++;
        end

    // One result per frame and never both kinds at once
    rx_exclusive_a: assert property (@(posedge clock) disable iff (reset)
        rx_valid || rx_error |-> !(rx_valid && rx_error) ##1 !(rx_valid || rx_error))
        else begin
            $error("rx valid and frame error high together");
            assert_fails++;
        end

    // Idle only once the frame time is over
    tx_idle_low_a: assert property (@(posedge clock) disable iff (reset)
        tx_state == TX_IDLE |-> busy_left == 0 && !lane1 && !lane2)
        else begin
            $error("laser lane high while the transmitter is idle");
            assert_fails++;
        end

endmodule

bind laser_serializer laser_link_assert u_tx_assert (
    .clock    (clock),
    .reset    (reset),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx_state (state),
    .lane1    (laser1_out),
    .lane2    (laser2_out),
    .rx_valid (1'b0),
    .rx_error (1'b0)
);

bind laser_deserializer laser_link_assert u_rx_assert (
    .clock    (clock),
    .reset    (reset),
    .tx_valid (1'b0),
    .tx_ready (1'b0),
    .tx_state (laser_line_pkg::TX_IDLE),
    .lane1    (1'b0),
    .lane2    (1'b0),
    .rx_valid (frame.valid),
    .rx_error (frame.frame_error)
);

// File: sim/laser_link_input.txt
# kind lane1 lane2 arg, hex; kind 0 clean, 1 glitch, 2 bad stop, 3 back-pressure, 4 handshake
# arg: frame bit 1..8 to glitch for kind 1, lane with the high stop bit for kind 2, else 0
0 3c c3 0
0 00 ff 0
1 a5 5a 1
1 ff 00 8
1 81 7e 4
2 12 34 1
2 56 78 2
3 de ad 0
4 55 aa 0
4 55 aa 0
4 13 57 0
4 55 aa 0
4 55 aa 0
4 55 aa 0
4 55 aa 0
4 e7 18 0
4 aa aa 0
0 55 aa 0

// File: sim/laser_link_tb.sv
`timescale 1ns/1ps

`include "laser_link_defines.svh"

module laser_link_tb;

    localparam int CLOCK_PERIOD = 40;
    localparam int FRAME_CLOCKS = `FRAME_BITS * `BIT_CLOCKS;
    localparam int WAIT_LIMIT   = 3 * FRAME_CLOCKS;

    logic       clock;
    logic       reset;
    logic       tx_valid;
    logic [7:0] tx_data1;
    logic [7:0] tx_data2;
    logic       tx_ready;
    logic       laser1_out;
    logic       laser2_out;
    logic       laser1_in;
    logic       laser2_in;
    logic       rx_valid;
    logic       rx_frame_error;
    logic       link_up;
    logic [7:0] rx_data1;
    logic [7:0] rx_data2;

    // Loopback with a one-clock inversion per lane or direct drive
    logic        loop_en;
    logic        flip1;
    logic        flip2;
    logic        direct1;
    logic        direct2;

    logic [7:0]  kind_q[$];
    logic [7:0]  byte1_q[$];
    logic [7:0]  byte2_q[$];
    logic [7:0]  arg_q[$];
    logic [15:0] rx_q[$];
    int          rx_errors;
    int          error_count;
    int          pass_count;
    int          fail_count;
    int          hs_count;
    logic        exp_link_up;
    logic        link_check_due;
    bit          loaded;

    assign laser1_in = loop_en ? (laser1_out ^ flip1) : direct1;
    assign laser2_in = loop_en ? (laser2_out ^ flip2) : direct2;

    laser_link_top u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: actual %0h, expected %0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Failure: %s", what);
        error_count++;
    endtask

    function automatic int assertion_failures();
        return u_dut.u_serializer.u_tx_assert.assert_fails
               + u_dut.u_deserializer.u_rx_assert.assert_fails;
    endfunction

    function automatic string test_name(input logic [7:0] kind);
        case (kind)
            8'h0:    return "clean transfer";
            8'h1:    return "glitch tolerance";
            8'h2:    return "framing error";
            8'h3:    return "back-pressure";
            8'h4:    return "handshake frame";
            default: return "unknown kind";
        endcase
    endfunction

    task automatic load_tests();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [7:0]       b1;
        logic [7:0]       b2;
        logic [7:0]       arg;
        logic [8*100-1:0] skipped;
        fd = $fopen("sim/laser_link_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%h %h %h %h\n", kind, b1, b2, arg);
                if (code == 4) begin
                    kind_q.push_back(kind);
                    byte1_q.push_back(b1);
                    byte2_q.push_back(b2);
                    arg_q.push_back(arg);
                end else begin
                    // Comment line
                    code = $fgets(skipped, fd);
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end
    endtask

    // Starts on a falling edge and returns on the one after acceptance
    task automatic send_pair(input logic [7:0] d1, input logic [7:0] d2);
        int cycles;
        cycles = 0;
        tx_data1 = d1;
        tx_data2 = d2;
        tx_valid = 1'b1;
        while (!tx_ready && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!tx_ready)
            note_failure("transmitter never became ready");
        @(negedge clock);
        tx_valid = 1'b0;
    endtask

    task automatic expect_pair(input logic [7:0] d1, input logic [7:0] d2);
        int          cycles;
        logic [15:0] pair;
        cycles = 0;
        while (rx_q.size() == 0 && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (rx_q.size() == 0) begin
            note_failure("no frame received within the wait limit");
        end else begin
            pair = rx_q.pop_front();
            check_value("rx_data1", pair[7:0], d1);
            check_value("rx_data2", pair[15:8], d2);
        end
    endtask

    task automatic run_test(input logic [7:0] kind, input logic [7:0] d1,
                            input logic [7:0] d2, input logic [7:0] arg);
        logic [`FRAME_BITS-1:0] frame1;
        logic [`FRAME_BITS-1:0] frame2;
        int                     offset;
        int                     count;
        int                     start_errors;
        case (kind)
            8'h0, 8'h4: begin
                send_pair(d1, d2);
                expect_pair(d1, d2);
            end
            8'h1: begin
                // One bad sample inside the vote window of frame bit arg
                offset = arg * `BIT_CLOCKS + `VOTE_FIRST - 1
                         + ($urandom % (`VOTE_LAST - `VOTE_FIRST + 1));
                send_pair(d1, d2);
                repeat (offset) @(negedge clock);
                if ($urandom % 2)
                    flip2 = 1'b1;
                else
                    flip1 = 1'b1;
                @(negedge clock);
                flip1 = 1'b0;
                flip2 = 1'b0;
                expect_pair(d1, d2);
            end
            8'h2: begin
                // Stop bit high on lane arg
                frame1 = {arg == 8'h1, d1, 1'b1};
                frame2 = {arg != 8'h1, d2, 1'b1};
                start_errors = rx_errors;
                loop_en = 1'b0;
                for (offset = 0; offset < FRAME_CLOCKS; offset++) begin
                    direct1 = frame1[offset / `BIT_CLOCKS];
                    direct2 = frame2[offset / `BIT_CLOCKS];
                    @(negedge clock);
                end
                direct1 = 1'b0;
                direct2 = 1'b0;
                count = 0;
                while (rx_errors == start_errors && count < WAIT_LIMIT) begin
                    @(negedge clock);
                    count++;
                end
                if (rx_errors == start_errors)
                    note_failure("no frame error reported for a high stop bit");
                check_value("rx_valid count", rx_q.size(), 0);
                loop_en = 1'b1;
            end
            8'h3: begin
                send_pair(d1, d2);
                // Second pair waits at tx_valid for the whole first frame
                tx_data1 = ~d1;
                tx_data2 = ~d2;
                tx_valid = 1'b1;
                count = 0;
                while (!tx_ready && count < WAIT_LIMIT) begin
                    count++;
                    @(negedge clock);
                end
                check_value("tx_ready low cycles", count, FRAME_CLOCKS);
                @(negedge clock);
                tx_valid = 1'b0;
                expect_pair(d1, d2);
                expect_pair(~d1, ~d2);
            end
            default: note_failure("unknown test kind in the data file");
        endcase
    endtask

    // Collects received frames and tracks the expected link state
    initial begin
        forever begin
            @(negedge clock);
            if (link_check_due) begin
                check_value("link_up", link_up, exp_link_up);
                link_check_due = 1'b0;
            end
            if (!reset && rx_valid) begin
                rx_q.push_back({rx_data2, rx_data1});
                link_check_due = 1'b1;
                if (!exp_link_up && rx_data1 == `HS_LANE1 && rx_data2 == `HS_LANE2) begin
                    hs_count++;
                    exp_link_up = (hs_count == `HS_REPEAT);
                end else if (!exp_link_up) begin
                    hs_count = 0;
                end else if (rx_data1 == `DONE_CODE && rx_data2 == `DONE_CODE) begin
                    exp_link_up = 1'b0;
                    hs_count = 0;
                end
            end
            if (!reset && rx_frame_error) begin
                rx_errors++;
                if (!exp_link_up)
                    hs_count = 0;
            end
        end
    end

    // Watchdog sized from the number of tests
    initial begin
        wait (loaded);
        #((kind_q.size() * 2 * FRAME_CLOCKS + 16) * CLOCK_PERIOD);
        $display("Run stopped by the watchdog at %0t", $time);
        $display("Errors found");
        $finish;
    end

    initial begin
        int    k;
        int    errors_before;
        string verdict;
        void'($urandom(32'h0555_669a));
        reset = 1'b1;
        tx_valid = 1'b0;
        tx_data1 = 8'h00;
        tx_data2 = 8'h00;
        loop_en = 1'b1;
        flip1 = 1'b0;
        flip2 = 1'b0;
        direct1 = 1'b0;
        direct2 = 1'b0;
        rx_errors = 0;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        hs_count = 0;
        exp_link_up = 1'b0;
        link_check_due = 1'b0;
        loaded = 1'b0;
        load_tests();
        repeat (8) @(negedge clock);
        reset = 1'b0;
        if (!loaded) begin
            $display("Could not open sim/laser_link_input.txt");
            $display("Errors found");
            $finish;
        end else begin
            check_value("tx_ready", tx_ready, 1);
            check_value("laser1_out", laser1_out, 0);
            check_value("laser2_out", laser2_out, 0);
            check_value("rx_valid", rx_valid, 0);
            check_value("rx_frame_error", rx_frame_error, 0);
            check_value("link_up", link_up, 0);
            $display("Test 0, reset state: %s", (error_count == 0) ? "PASS" : "FAIL");
            for (k = 0; k < kind_q.size(); k++) begin
                errors_before = error_count + assertion_failures();
                run_test(kind_q[k], byte1_q[k], byte2_q[k], arg_q[k]);
                repeat (2) @(negedge clock);
                if (error_count + assertion_failures() == errors_before) begin
                    verdict = "PASS";
                    pass_count++;
                end else begin
                    verdict = "FAIL";
                    fail_count++;
                end
                $display("Test %0d, %s: %s", k + 1, test_name(kind_q[k]), verdict);
            end
            $display("Tests passed %0d, failed %0d, check errors %0d, assertion errors %0d",
                     pass_count, fail_count, error_count, assertion_failures());
            if (error_count + assertion_failures() == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// File: src.f
+incdir+common
common/laser_line_pkg.sv
common/link_pkg.sv
common/rx_frame_if.sv
laser_tx/laser_serializer.sv
laser_rx/lane_sampler.sv
laser_rx/laser_deserializer.sv
hdl/link_monitor.sv
hdl/laser_link_top.sv
sim/laser_link_assert.sv
sim/laser_link_tb.sv
